// File: build.f
i2c_pkg.sv
i2c_phase_timer.sv
i2c_byte_shifter.sv
i2c_master_fsm.sv
i2c_master.sv
tb_i2c_target.sv
tb_i2c_checker.sv
tb_i2c_master.sv

// File: tb_i2c_master.sv
/* I2C controller testbench
   clock, reset, pull-ups, command and stream stimulus and the closing summary */
`timescale 1ns/1ps
module tb_i2c_master;
    import i2c_pkg::*;

    localparam int unsigned CLK_FREQ = 50_000_000;
    localparam int          TIMEOUT  = 20000; // clock cycles allowed for any single wait

    logic       clk, rst;
    logic       cmd_valid, cmd_ready;
    i2c_op_t    cmd_op;
    logic [6:0] cmd_dev_addr;
    logic [7:0] cmd_reg_addr, wr_data, rd_data;
    logic [3:0] cmd_len;
    logic       wr_valid, wr_ready, rd_valid, rd_ready, rsp_valid, rsp_ready, rsp_nack;
    wire        scl, sda;
    wire [127:0] mem_image;
    int         error_count, check_count;
    int         errors_before = 0;
    int         tests_run = 0;
    integer     seed = 32'h0327e928;
    logic       gaps_on, wr_fire;
    logic [7:0] wr_queue [$];

    pullup (scl);
    pullup (sda);

    i2c_master #(.CLK_FREQ(CLK_FREQ)) i_dut (
        .clk, .rst, .cmd_valid, .cmd_ready, .cmd_op, .cmd_dev_addr, .cmd_reg_addr, .cmd_len,
        .wr_valid, .wr_ready, .wr_data, .rd_valid, .rd_ready, .rd_data,
        .rsp_valid, .rsp_ready, .rsp_nack, .scl, .sda
    );

    tb_i2c_target i_target (.scl, .sda, .mem_image);

    tb_i2c_checker i_checker (
        .clk, .rst, .cmd_valid, .cmd_ready, .cmd_op, .cmd_dev_addr, .cmd_reg_addr, .cmd_len,
        .wr_valid, .wr_ready, .wr_data, .rd_valid, .rd_ready, .rd_data,
        .rsp_valid, .rsp_ready, .rsp_nack, .mem_image, .error_count, .check_count
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) wr_fire <= wr_valid && wr_ready;

    // write bytes come from the queue, with random gaps and ready drops once enabled
    always @(posedge clk) begin
        if (wr_fire) void'(wr_queue.pop_front());
        if (wr_valid && !wr_fire && wr_queue.size() > 0) begin
            wr_valid <= 1'b1; // an offered byte stays until it is taken
        end else if (wr_queue.size() > 0 && (!gaps_on || ($random(seed) & 63) == 0)) begin
            wr_valid <= 1'b1;
            wr_data  <= wr_queue[0];
        end else begin
            wr_valid <= 1'b0;
        end
        if (!gaps_on) begin
            rd_ready  <= 1'b1;
            rsp_ready <= 1'b1;
        end else begin
            if (($random(seed) & 15) == 0) rd_ready <= !rd_ready;
            if (($random(seed) & 15) == 0) rsp_ready <= !rsp_ready;
        end
    end

    task automatic wait_cmd_ready(output logic seen);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!cmd_ready && waited < TIMEOUT);
        seen = cmd_ready;
        if (!seen) i_checker.report_failure("cmd_ready did not rise within the timeout");
    endtask

    task automatic run_command(input i2c_op_t op, input logic [6:0] dev,
                               input logic [7:0] reg_addr, input logic [3:0] len);
        logic seen;
        int   waited;
        @(posedge clk);
        cmd_valid    <= 1'b1;
        cmd_op       <= op;
        cmd_dev_addr <= dev;
        cmd_reg_addr <= reg_addr;
        cmd_len      <= len;
        wait_cmd_ready(seen);
        @(posedge clk);
        cmd_valid <= 1'b0;
        if (seen) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!(rsp_valid && rsp_ready) && waited < TIMEOUT);
            if (!(rsp_valid && rsp_ready)) begin
                i_checker.report_failure("no response arrived within the timeout");
            end
            @(posedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        if (error_count == errors_before) $display("%s: ok", name);
        else $display("%s: %0d errors", name, error_count - errors_before);
        errors_before = error_count;
        tests_run++;
    endtask

    initial begin
        logic       seen;
        logic [3:0] len;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = OP_WRITE;
        cmd_dev_addr = '0;
        cmd_reg_addr = '0;
        cmd_len = '0;
        wr_valid = 1'b0;
        wr_data = '0;
        rd_ready = 1'b1;
        rsp_ready = 1'b1;
        gaps_on = 1'b0;
        wr_fire = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        i_checker.check_value("scl", 8'h01, 8'(scl));
        i_checker.check_value("sda", 8'h01, 8'(sda));
        i_checker.check_value("rsp_valid", 8'h00, 8'(rsp_valid));
        i_checker.check_value("rd_valid", 8'h00, 8'(rd_valid));
        i_checker.check_value("wr_ready", 8'h00, 8'(wr_ready));
        i_checker.check_value("cmd_ready", 8'h00, 8'(cmd_ready));
        wait_cmd_ready(seen);
        finish_test("reset state");

        for (int i = 0; i < 3; i++) wr_queue.push_back(8'($random(seed)));
        run_command(OP_WRITE, 7'h48, 8'($random(seed)), 4'd3);
        i_checker.check_memory();
        finish_test("register write");

        wr_queue.push_back(8'($random(seed)));
        run_command(OP_WRITE, 7'h48, 8'h09, 4'd1);
        run_command(OP_READ, 7'h48, 8'h00, 4'd4);
        finish_test("write then read");

        wr_queue.push_back(8'($random(seed)));
        wr_queue.push_back(8'($random(seed)));
        run_command(OP_WRITE, 7'h21, 8'h03, 4'd2);
        i_checker.check_memory();
        wr_queue.delete(); // the absent device never takes these bytes
        finish_test("absent device");

        gaps_on <= 1'b1;
        for (int round = 0; round < 3; round++) begin
            len = 4'(1 + ($random(seed) & 3));
            for (int i = 0; i < len; i++) wr_queue.push_back(8'($random(seed)));
            run_command(OP_WRITE, 7'h48, 8'($random(seed)), len);
            run_command(OP_READ, 7'h48, 8'h00, 4'(1 + ($random(seed) & 3)));
        end
        i_checker.check_memory();
        finish_test("stream back-pressure");

        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tb_i2c_checker.sv
/* I2C testbench checker
   shadow register file that predicts read bytes, responses and target memory */
`timescale 1ns/1ps
module tb_i2c_checker #(
    parameter logic [6:0] DEV_ADDR = 7'h48
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_valid,
    input  logic             cmd_ready,
    input  i2c_pkg::i2c_op_t cmd_op,
    input  logic [6:0]       cmd_dev_addr,
    input  logic [7:0]       cmd_reg_addr,
    input  logic [3:0]       cmd_len,
    input  logic             wr_valid,
    input  logic             wr_ready,
    input  logic [7:0]       wr_data,
    input  logic             rd_valid,
    input  logic             rd_ready,
    input  logic [7:0]       rd_data,
    input  logic             rsp_valid,
    input  logic             rsp_ready,
    input  logic             rsp_nack,
    input  logic [127:0]     mem_image,
    output int               error_count,
    output int               check_count
);
    import i2c_pkg::*;

    logic [7:0] shadow [0:15];
    logic [3:0] shadow_ptr = '0;
    logic       dev_present = 1'b1;
    logic       in_flight = 1'b0;  // a command was taken and its response is still open
    int         wr_expected = 0;   // data bytes the open command should move in each direction
    int         rd_expected = 0;
    int         wr_seen = 0;
    int         rd_seen = 0;
    int         errors = 0;
    int         checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // kind 0 sets the pointer, kind 1 stores a write byte, kind 2 fetches a read byte
    function automatic logic [7:0] ref_model(input int kind, input logic [7:0] value);
        logic [7:0] result;
        result = value;
        case (kind)
            0: shadow_ptr = value[3:0];
            1: begin
                shadow[shadow_ptr] = value;
                shadow_ptr         = shadow_ptr + 1'b1;
            end
            default: begin
                result     = shadow[shadow_ptr];
                shadow_ptr = shadow_ptr + 1'b1;
            end
        endcase
        return result;
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    task automatic check_memory();
        for (int i = 0; i < 16; i++) begin
            check_value($sformatf("target mem[%0d]", i), shadow[i], mem_image[i*8 +: 8]);
        end
    endtask

    always @(negedge rst) begin
        for (int i = 0; i < 16; i++) shadow[i] = mem_image[i*8 +: 8];
    end

    // handshakes seen at the falling edge complete at the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (cmd_ready && in_flight) report_failure("cmd_ready rose before the response was taken");
            if (cmd_valid && cmd_ready) begin
                in_flight   = 1'b1;
                dev_present = (cmd_dev_addr == DEV_ADDR);
                wr_expected = (dev_present && cmd_op == OP_WRITE) ? int'(cmd_len) : 0;
                rd_expected = (dev_present && cmd_op == OP_READ) ? int'(cmd_len) : 0;
                wr_seen     = 0;
                rd_seen     = 0;
                if (dev_present && cmd_op == OP_WRITE) void'(ref_model(0, cmd_reg_addr));
            end
            if (wr_ready && !dev_present) report_failure("write byte requested for an absent device");
            if (wr_valid && wr_ready) wr_seen++;
            if (wr_valid && wr_ready && dev_present) void'(ref_model(1, wr_data));
            if (rd_valid && rd_ready) begin
                rd_seen++;
                check_value("rd_data", ref_model(2, 8'h00), rd_data);
            end
            if (rsp_valid && rsp_ready) begin
                check_value("rsp_nack", 8'(!dev_present), 8'(rsp_nack));
                check_value("write byte count", 8'(wr_expected), 8'(wr_seen));
                check_value("read byte count", 8'(rd_expected), 8'(rd_seen));
                in_flight = 1'b0;
            end
        end
    end

endmodule

// File: tb_i2c_target.sv
/* I2C bus target model
   16-byte register file behind one device address with an auto-incrementing pointer */
`timescale 1ns/1ps
module tb_i2c_target #(
    parameter logic [6:0] DEV_ADDR = 7'h48
) (
    inout  wire          scl,
    inout  wire          sda,
    output logic [127:0] mem_image
);
    logic [7:0] mem [0:15];
    logic [7:0] shreg;
    logic [3:0] ptr;
    logic       sda_low, active, addr_phase, reading, ptr_set, nacked;
    int         bit_cnt;          // clock pulses seen in the current byte, 9 after the ack

    assign sda = sda_low ? 1'b0 : 1'bz;

    for (genvar i = 0; i < 16; i++) begin : g_image
        assign mem_image[i*8 +: 8] = mem[i];
    end

    initial begin
        sda_low    = 1'b0;
        active     = 1'b0;
        addr_phase = 1'b0;
        reading    = 1'b0;
        ptr_set    = 1'b0;
        nacked     = 1'b0;
        bit_cnt    = 0;
        ptr        = '0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = 8'(i * 37 + 3); // every address bit changes the fill value
        end
    end

    always @(negedge sda) begin
        if (scl === 1'b1) begin // start condition
            active     = 1'b1;
            addr_phase = 1'b1;
            bit_cnt    = 0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin // stop condition
            active  = 1'b0;
            sda_low = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (active) begin
            if (bit_cnt < 8 && !(reading && !addr_phase)) shreg = {shreg[6:0], sda};
            if (bit_cnt == 8 && reading && !addr_phase) nacked = (sda !== 1'b0);
            bit_cnt = bit_cnt + 1;
        end
    end

    // all changes on SDA happen while SCL is low
    always @(negedge scl) begin
        if (active) begin
            if (bit_cnt == 8) begin
                if (addr_phase) begin
                    if (shreg[7:1] == DEV_ADDR) begin
                        sda_low = 1'b1;
                        reading = shreg[0];
                        ptr_set = 1'b0;
                        nacked  = 1'b0;
                    end else begin
                        active = 1'b0; // not addressed, so the master sees a nack
                    end
                end else if (!reading) begin
                    if (ptr_set) begin
                        mem[ptr] = shreg;
                        ptr      = ptr + 1'b1;
                    end else begin
                        ptr     = shreg[3:0]; // first written byte selects the register
                        ptr_set = 1'b1;
                    end
                    sda_low = 1'b1;
                end else begin
                    sda_low = 1'b0; // the master answers read bytes
                end
            end else if (bit_cnt == 9) begin
                bit_cnt    = 0;
                addr_phase = 1'b0;
                if (reading && !nacked) begin
                    shreg   = mem[ptr];
                    ptr     = ptr + 1'b1;
                    sda_low = !shreg[7];
                end else begin
                    sda_low = 1'b0;
                    if (reading) active = 1'b0;
                end
            end else if (reading && !addr_phase) begin
                sda_low = !shreg[7 - bit_cnt];
            end
        end
    end

endmodule

// File: i2c_master.sv
/* I2C bus controller top level
   sequencer, phase timer and byte shifter behind open-drain SCL and SDA pins */
`timescale 1ns/1ps
module i2c_master #(
    parameter int unsigned CLK_FREQ = 50_000_000
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  i2c_pkg::i2c_op_t               cmd_op,
    input  logic [i2c_pkg::DEV_ADDR_W-1:0] cmd_dev_addr,
    input  logic [i2c_pkg::BYTE_W-1:0]     cmd_reg_addr,
    input  logic [i2c_pkg::LEN_W-1:0]      cmd_len,
    input  logic                           wr_valid,
    output logic                           wr_ready,
    input  logic [i2c_pkg::BYTE_W-1:0]     wr_data,
    output logic                           rd_valid,
    input  logic                           rd_ready,
    output logic [i2c_pkg::BYTE_W-1:0]     rd_data,
    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output logic                           rsp_nack,
    inout  wire                            scl,
    inout  wire                            sda
);
    import i2c_pkg::*;

    i2c_phase_t        phase;
    logic              load, expired;
    logic              byte_load, shift, sample_bit;
    logic [BYTE_W-1:0] load_data, rx_byte;
    logic              tx_bit, last_bit;
    logic              scl_drive_low, sda_drive_low, sda_in;

    assign scl    = scl_drive_low ? 1'b0 : 1'bz; // open drain, the pull-ups raise the lines
    assign sda    = sda_drive_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    i2c_master_fsm i_fsm (
        .clk, .rst,
        .cmd_valid, .cmd_ready, .cmd_op, .cmd_dev_addr, .cmd_reg_addr, .cmd_len,
        .wr_valid, .wr_ready, .wr_data,
        .rd_valid, .rd_ready, .rd_data,
        .rsp_valid, .rsp_ready, .rsp_nack,
        .sda_in, .scl_drive_low, .sda_drive_low,
        .phase, .load, .expired,
        .byte_load, .load_data, .shift, .sample_bit,
        .tx_bit, .rx_byte, .last_bit
    );

    i2c_phase_timer #(.CLK_FREQ(CLK_FREQ)) i_timer (
        .clk, .rst, .load, .phase, .expired
    );

    i2c_byte_shifter i_shifter (
        .clk, .rst,
        .load(byte_load), .load_data, .shift, .sample_bit, .sda_in,
        .tx_bit, .rx_byte, .last_bit
    );

endmodule

// File: i2c_master_fsm.sv
/* I2C transaction sequencer
   walks address, register and data bytes and runs the stream handshakes */
`timescale 1ns/1ps
module i2c_master_fsm (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  i2c_pkg::i2c_op_t               cmd_op,
    input  logic [i2c_pkg::DEV_ADDR_W-1:0] cmd_dev_addr,
    input  logic [i2c_pkg::BYTE_W-1:0]     cmd_reg_addr,
    input  logic [i2c_pkg::LEN_W-1:0]      cmd_len,
    input  logic                           wr_valid,
    output logic                           wr_ready,
    input  logic [i2c_pkg::BYTE_W-1:0]     wr_data,
    output logic                           rd_valid,
    input  logic                           rd_ready,
    output logic [i2c_pkg::BYTE_W-1:0]     rd_data,
    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output logic                           rsp_nack,
    input  logic                           sda_in,
    output logic                           scl_drive_low,
    output logic                           sda_drive_low,
    output i2c_pkg::i2c_phase_t            phase,
    output logic                           load,
    input  logic                           expired,
    output logic                           byte_load,
    output logic [i2c_pkg::BYTE_W-1:0]     load_data,
    output logic                           shift,
    output logic                           sample_bit,
    input  logic                           tx_bit,
    input  logic [i2c_pkg::BYTE_W-1:0]     rx_byte,
    input  logic                           last_bit
);
    import i2c_pkg::*;

    i2c_state_t        state, state_next;
    i2c_op_t           op_q;
    logic [BYTE_W-1:0] reg_q;
    logic [LEN_W-1:0]  len_q;      // data bytes left, the current one included
    logic addr_byte, reg_byte;     // which byte of the transaction is on the bus
    logic need_data;               // write byte still waits for the write-data stream
    logic ack_setup;               // ACK_LOW has moved on to its setup part
    logic timer_idle;              // the last phase expired and nothing was reloaded
    logic nack_q;
    logic sda_q, sda_next;
    logic tick, rd_byte, last_byte, rd_hold;

    assign tick      = expired | timer_idle;
    assign rd_byte   = !addr_byte && !reg_byte && (op_q == OP_READ);
    assign last_byte = !addr_byte && !reg_byte && (len_q == LEN_W'(1));
    assign rd_hold   = rd_valid && !rd_ready;

    always_comb begin
        state_next = state;
        load       = 1'b0;
        phase      = PH_LOW;
        byte_load  = 1'b0;
        load_data  = '1;
        shift      = 1'b0;
        sample_bit = 1'b0;
        wr_ready   = 1'b0;
        case (state)
            BUS_FREE: if (expired) state_next = IDLE;
            IDLE: if (cmd_valid) begin
                state_next = START_HOLD;
                load       = 1'b1;
                phase      = PH_START_HOLD;
                byte_load  = 1'b1;
                load_data  = {cmd_dev_addr, cmd_op};
            end
            START_HOLD: if (expired) begin
                state_next = BIT_LOW;
                load       = 1'b1;
            end
            BIT_LOW: if (tick && (!need_data || wr_valid)) begin
                state_next = BIT_SETUP;
                load       = 1'b1;
                phase      = PH_SETUP;
                if (need_data) begin // SCL stays low until a write byte is offered
                    wr_ready  = 1'b1;
                    byte_load = 1'b1;
                    load_data = wr_data;
                end
            end
            BIT_SETUP: if (expired) begin
                state_next = BIT_HIGH;
                load       = 1'b1;
                phase      = PH_HIGH;
                sample_bit = 1'b1;
            end
            BIT_HIGH: if (expired) begin
                state_next = last_bit ? ACK_LOW : BIT_LOW;
                load       = 1'b1;
                shift      = 1'b1;
            end
            ACK_LOW: begin
                if (!ack_setup && expired) begin
                    load  = 1'b1;
                    phase = PH_SETUP;
                end else if (ack_setup && tick && !rd_hold) begin
                    state_next = ACK_HIGH;
                    load       = 1'b1;
                    phase      = PH_HIGH;
                end
            end
            ACK_HIGH: if (expired) begin
                load = 1'b1;
                if (nack_q || last_byte) begin
                    state_next = STOP_LOW;
                    phase      = PH_STOP_LOW;
                end else begin
                    state_next = BIT_LOW;
                    if (addr_byte && op_q == OP_WRITE) begin
                        byte_load = 1'b1;
                        load_data = reg_q;
                    end else if (op_q == OP_READ) begin
                        byte_load = 1'b1; // all ones leave SDA to the target
                    end
                end
            end
            STOP_LOW: if (expired) begin
                state_next = STOP_SETUP;
                load       = 1'b1;
                phase      = PH_STOP_SETUP;
            end
            STOP_SETUP: if (expired) state_next = RESPOND;
            RESPOND: if (rsp_ready) begin
                state_next = BUS_FREE;
                load       = 1'b1;
                phase      = PH_BUS_FREE;
            end
            default: state_next = BUS_FREE;
        endcase
    end

    // SDA follows one clock behind the state, so it always moves after SCL has fallen
    always_comb begin
        case (state)
            START_HOLD, STOP_LOW, STOP_SETUP: sda_next = 1'b1;
            BIT_LOW, BIT_SETUP, BIT_HIGH:     sda_next = !need_data && !tx_bit;
            ACK_LOW, ACK_HIGH:                sda_next = rd_byte && !last_byte;
            default:                          sda_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= BUS_FREE;
            op_q       <= OP_WRITE;
            len_q      <= '0;
            addr_byte  <= 1'b0;
            reg_byte   <= 1'b0;
            need_data  <= 1'b0;
            ack_setup  <= 1'b0;
            timer_idle <= 1'b0;
            nack_q     <= 1'b0;
            rd_valid   <= 1'b0;
            sda_q      <= 1'b0;
        end else begin
            state <= state_next;
            sda_q <= sda_next;
            if (load) timer_idle <= 1'b0;
            else if (expired) timer_idle <= 1'b1;
            if (state == IDLE && cmd_valid) begin
                op_q      <= cmd_op;
                len_q     <= cmd_len;
                addr_byte <= 1'b1;
                reg_byte  <= 1'b0;
                need_data <= 1'b0;
                nack_q    <= 1'b0;
            end
            if (wr_ready) need_data <= 1'b0;
            if (state == ACK_LOW && load) begin
                ack_setup <= !ack_setup;
                if (ack_setup && !rd_byte) nack_q <= sda_in; // target ack at the rising edge
            end
            if (rd_valid && rd_ready) rd_valid <= 1'b0;
            else if (state == BIT_HIGH && expired && last_bit && rd_byte) rd_valid <= 1'b1;
            if (state == ACK_HIGH && state_next == BIT_LOW) begin
                if (addr_byte) begin
                    addr_byte <= 1'b0;
                    reg_byte  <= (op_q == OP_WRITE);
                end else begin
                    if (reg_byte) reg_byte <= 1'b0;
                    else len_q <= len_q - 1'b1;
                    need_data <= (op_q == OP_WRITE);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_valid) reg_q <= cmd_reg_addr;
    end

    assign cmd_ready     = (state == IDLE);
    assign rsp_valid     = (state == RESPOND);
    assign rsp_nack      = nack_q;
    assign rd_data       = rx_byte;
    assign sda_drive_low = sda_q;
    assign scl_drive_low = state inside {BIT_LOW, BIT_SETUP, ACK_LOW, STOP_LOW};

    a_cmd_ready_idle: assert property (@(posedge clk) disable iff (rst)
        cmd_ready |-> (state == IDLE && !rd_valid && !need_data))
        else $error("cmd_ready raised while a transaction is still open");

    a_rd_valid_hold: assert property (@(posedge clk) disable iff (rst)
        (rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_data)))
        else $error("read byte withdrawn or changed before rd_ready");

endmodule

// File: i2c_byte_shifter.sv
/* I2C byte shifter
   sends a byte msb first, collects sampled SDA bits and tracks the bit position */
`timescale 1ns/1ps
module i2c_byte_shifter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  logic [i2c_pkg::BYTE_W-1:0] load_data,
    input  logic                       shift,
    input  logic                       sample_bit,
    input  logic                       sda_in,
    output logic                       tx_bit,
    output logic [i2c_pkg::BYTE_W-1:0] rx_byte,
    output logic                       last_bit
);
    import i2c_pkg::*;

    localparam int CNT_W = $clog2(BYTE_W);

    logic [BYTE_W-1:0] tx_reg;
    logic [CNT_W-1:0]  bit_cnt;

    // bit position inside the current byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (load) begin
            bit_cnt <= '0;
        end else if (shift) begin
            bit_cnt <= bit_cnt + 1'b1; // wraps back to zero after the eighth bit
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tx_reg <= load_data;
        end else if (shift) begin
            tx_reg <= {tx_reg[BYTE_W-2:0], 1'b1}; // refill with ones so SDA stays released
        end
    end

    always_ff @(posedge clk) begin
        if (sample_bit) begin
            rx_byte <= {rx_byte[BYTE_W-2:0], sda_in};
        end
    end

    assign tx_bit   = tx_reg[BYTE_W-1];
    assign last_bit = (bit_cnt == CNT_W'(BYTE_W - 1));

endmodule

// File: i2c_phase_timer.sv
/* I2C phase timer
   loadable down-counter that measures each bus phase in clock cycles */
`timescale 1ns/1ps
module i2c_phase_timer #(
    parameter int unsigned CLK_FREQ = 50_000_000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  i2c_pkg::i2c_phase_t phase,
    output logic                expired
);
    import i2c_pkg::*;

    localparam logic [TIMER_W-1:0] BUS_FREE_CYC =
        TIMER_W'(ns_to_cycles(T_BUF_NS, CLK_FREQ));
    localparam logic [TIMER_W-1:0] START_HOLD_CYC =
        TIMER_W'(ns_to_cycles(T_HD_STA_NS + T_FALL_NS, CLK_FREQ));
    localparam logic [TIMER_W-1:0] LOW_CYC =
        TIMER_W'(ns_to_cycles(T_LOW_NS + T_FALL_NS - T_SU_DAT_NS, CLK_FREQ));
    localparam logic [TIMER_W-1:0] SETUP_CYC =
        TIMER_W'(ns_to_cycles(T_SU_DAT_NS + T_RISE_NS, CLK_FREQ));
    localparam logic [TIMER_W-1:0] HIGH_CYC =
        TIMER_W'(ns_to_cycles(T_HIGH_NS, CLK_FREQ));
    localparam logic [TIMER_W-1:0] STOP_LOW_CYC =
        TIMER_W'(ns_to_cycles(T_LOW_NS + T_FALL_NS, CLK_FREQ));
    localparam logic [TIMER_W-1:0] STOP_SETUP_CYC =
        TIMER_W'(ns_to_cycles(T_SU_STO_NS + T_RISE_NS, CLK_FREQ));

    logic [TIMER_W-1:0] count;
    logic [TIMER_W-1:0] phase_cycles;

    always_comb begin
        case (phase)
            PH_BUS_FREE:   phase_cycles = BUS_FREE_CYC;
            PH_START_HOLD: phase_cycles = START_HOLD_CYC;
            PH_SETUP:      phase_cycles = SETUP_CYC;
            PH_HIGH:       phase_cycles = HIGH_CYC;
            PH_STOP_LOW:   phase_cycles = STOP_LOW_CYC;
            PH_STOP_SETUP: phase_cycles = STOP_SETUP_CYC;
            default:       phase_cycles = LOW_CYC;
        endcase
    end

    // the bus counts as just released when reset ends, so bus-free time runs first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= BUS_FREE_CYC;
        end else if (load) begin
            count <= phase_cycles;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign expired = (count == TIMER_W'(1)); // one cycle, then the counter rests at zero

    a_load_when_idle: assert property (@(posedge clk) disable iff (rst)
        load |-> (count == '0 || expired))
        else $error("phase timer reloaded while a phase was still running");

endmodule

// File: i2c_pkg.sv
/* I2C controller shared definitions
   opcodes, sequencer states, timer phases and the bus timing figures */
package i2c_pkg;

    typedef enum logic [0:0] {
        OP_WRITE = 1'b0, // register write
        OP_READ  = 1'b1  // current-address read
    } i2c_op_t;

    typedef enum logic [4:0] {
        BUS_FREE, IDLE, START_HOLD,
        BIT_LOW, BIT_SETUP, BIT_HIGH,
        ACK_LOW, ACK_HIGH,
        STOP_LOW, STOP_SETUP, RESPOND
    } i2c_state_t;

    typedef enum logic [2:0] {
        PH_BUS_FREE, PH_START_HOLD, PH_LOW, PH_SETUP, PH_HIGH, PH_STOP_LOW, PH_STOP_SETUP
    } i2c_phase_t;

    localparam int TIMER_W    = 12;
    localparam int LEN_W      = 4;
    localparam int BYTE_W     = 8;
    localparam int DEV_ADDR_W = 7;

    localparam int unsigned T_RISE_NS   = 300;
    localparam int unsigned T_FALL_NS   = 300;
    localparam int unsigned T_BUF_NS    = 1400;
    localparam int unsigned T_HD_STA_NS = 600;
    localparam int unsigned T_SU_DAT_NS = 20;
    localparam int unsigned T_LOW_NS    = 1300;
    localparam int unsigned T_HIGH_NS   = 700; // 100 ns of margin over the minimum
    localparam int unsigned T_SU_STO_NS = 600;

    // rounds up so that no bus timing comes out shorter than its figure
    function automatic int unsigned ns_to_cycles(input int unsigned ns,
                                                 input int unsigned clk_hz);
        longint unsigned prod;
        prod = longint'(ns) * longint'(clk_hz);
        return int'((prod + 64'd999_999_999) / 64'd1_000_000_000);
    endfunction

endpackage
